//--- src/dram_macros.svh
`ifndef DRAM_MACROS_SVH
`define DRAM_MACROS_SVH

// Data bus
`define DQ_WIDTH   16 // One word per access

// Command and address pins
`define ADDR_WIDTH 17 // A[16:0]
`define BG_WIDTH   1  // Bank group pins
`define BA_WIDTH   1  // Bank pins

// Array geometry
`define ROW_WIDTH  4 // Row bits kept from A[3:0] on ACT
`define COL_WIDTH  4 // Column bits from A[3:0] on RD and WR
`define NUM_BANKS  4 // Two groups of two banks

// Bank spacing in clock cycles
`define T_RCD      3 // ACT to RD or WR
`define T_RP       3 // PRE to ACT

// Data latencies in clock cycles
`define CL         5 // RD edge to dq_out
`define CWL        4 // WR edge to dq_in sample

`endif

//--- src/dram_pkg.sv
`include "dram_macros.svh"

package dram_pkg;

  // Decoded command, one per cycle
  typedef enum logic [2:0]
  {
    NOP  = 3'd0, // Also deselect and parity reject
    ACT  = 3'd1, // Open a row
    RD   = 3'd2, // Column read
    WR   = 3'd3, // Column write
    PRE  = 3'd4, // Close one bank
    PREA = 3'd5  // Close every open bank
  } dram_cmd_e;

  // Per-bank life cycle
  typedef enum logic [1:0]
  {
    IDLE    = 2'd0, // Precharged, ACT allowed
    OPENING = 2'd1, // Waiting out tRCD
    OPEN    = 2'd2, // Row open, RD/WR/PRE allowed
    CLOSING = 2'd3  // Waiting out tRP
  } bank_state_e;

  // Bank group in the upper bits
  typedef logic [`BG_WIDTH+`BA_WIDTH-1:0] bank_id_t;

  typedef logic [`DQ_WIDTH-1:0] dq_word_t;

  // Array address of one access
  typedef struct packed
  {
    bank_id_t               bank;
    logic [`ROW_WIDTH-1:0]  row; // Open row of that bank
    logic [`COL_WIDTH-1:0]  col;
  } wr_req_t;

endpackage

//--- src/cmd_decoder.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module cmd_decoder
  import dram_pkg::*;
(
  input  logic                   act_n,
  input  logic [`ADDR_WIDTH-1:0] a,
  input  logic [`BG_WIDTH-1:0]   bg,
  input  logic [`BA_WIDTH-1:0]   ba,
  input  logic                   cs_n,
  input  logic                   cke,
  input  logic                   parity,
  output dram_cmd_e              cmd,
  output bank_id_t               bank,
  output logic                   par_err
);

  logic       selected;  // Device addressed this cycle
  logic       par_calc;  // Even parity over the command pins
  logic [2:0] op_bits;   // RAS/CAS/WE positions of A
  dram_cmd_e  raw_cmd;   // Before the parity gate

  assign selected = !cs_n && cke;
  assign par_calc = ^{act_n, a, bg, ba};
  assign par_err  = selected && (parity != par_calc);

  assign op_bits = a[`ADDR_WIDTH-1 -: 3]; // A16 A15 A14

  always_comb
  begin
    raw_cmd = NOP;
    if (!act_n)
      raw_cmd = ACT; // A carries the row
    else
    begin
      case (op_bits)
        3'b101:  raw_cmd = RD;
        3'b100:  raw_cmd = WR;
        3'b010:  raw_cmd = a[10] ? PREA : PRE; // A10 picks all banks
        default: raw_cmd = NOP;
      endcase
    end
  end

  // Rejected on deselect or bad parity
  assign cmd  = (selected && !par_err) ? raw_cmd : NOP;
  assign bank = {bg, ba};

endmodule

//--- src/bank_ctrl.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module bank_ctrl
  import dram_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  dram_cmd_e              cmd,
  input  bank_id_t               bank,
  input  logic [`ADDR_WIDTH-1:0] a,
  input  logic                   par_err,
  output logic                   rd_en,
  output logic                   wr_en,
  output wr_req_t                req,
  output logic                   illegal_cmd,
  output logic                   alert
);

  // Wide enough for the longer of the two spacings
  localparam int T_MAX = (`T_RCD > `T_RP) ? `T_RCD : `T_RP;
  localparam int CNT_W = $clog2(T_MAX + 1);

  bank_state_e             state_q [`NUM_BANKS];
  logic [`ROW_WIDTH-1:0]   row_q   [`NUM_BANKS]; // Row latched on ACT
  logic [CNT_W-1:0]        cnt_q   [`NUM_BANKS]; // Cycles left in OPENING/CLOSING

  bank_state_e             sel_state; // State of the addressed bank
  logic                    illegal;
  logic                    act_go;
  logic                    pre_go;
  logic [`NUM_BANKS-1:0]   load_rcd; // Start tRCD countdown
  logic [`NUM_BANKS-1:0]   load_rp;  // Start tRP countdown

  assign sel_state = state_q[bank];

  // Legality against the addressed bank
  always_comb
  begin
    case (cmd)
      ACT:         illegal = (sel_state != IDLE);
      RD, WR, PRE: illegal = (sel_state != OPEN);
      default:     illegal = 1'b0; // NOP and PREA
    endcase
  end

  assign act_go = (cmd == ACT) && (sel_state == IDLE);
  assign pre_go = (cmd == PRE) && (sel_state == OPEN);
  assign rd_en  = (cmd == RD) && (sel_state == OPEN);
  assign wr_en  = (cmd == WR) && (sel_state == OPEN);

  always_comb
  begin
    for (int i = 0; i < `NUM_BANKS; i++)
    begin
      load_rcd[i] = act_go && (bank == bank_id_t'(i));
      load_rp[i]  = (pre_go && (bank == bank_id_t'(i))) ||
                    ((cmd == PREA) && (state_q[i] == OPEN)); // PREA skips non-open banks
    end
  end

  // Address for the array and the write delay line
  assign req.bank = bank;
  assign req.row  = row_q[bank];
  assign req.col  = a[`COL_WIDTH-1:0];

  // Bank FSMs
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `NUM_BANKS; i++)
      begin
        state_q[i] <= IDLE;
        cnt_q[i]   <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < `NUM_BANKS; i++)
      begin
        case (state_q[i])
          IDLE:
          begin
            if (load_rcd[i])
            begin
              state_q[i] <= OPENING;
              cnt_q[i]   <= CNT_W'(`T_RCD - 1);
            end
          end
          OPENING:
          begin
            if (cnt_q[i] == CNT_W'(1))
              state_q[i] <= OPEN; // Access legal from the next edge
            cnt_q[i] <= cnt_q[i] - 1'b1;
          end
          OPEN:
          begin
            if (load_rp[i])
            begin
              state_q[i] <= CLOSING;
              cnt_q[i]   <= CNT_W'(`T_RP - 1);
            end
          end
          default: // CLOSING
          begin
            if (cnt_q[i] == CNT_W'(1))
              state_q[i] <= IDLE;
            cnt_q[i] <= cnt_q[i] - 1'b1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < `NUM_BANKS; i++)
      if (load_rcd[i])
        row_q[i] <= a[`ROW_WIDTH-1:0];
  end

  // Error pulses one cycle after the command
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      illegal_cmd <= 1'b0;
      alert       <= 1'b0;
    end
    else
    begin
      illegal_cmd <= illegal;
      alert       <= par_err;
    end
  end

  // Counters start only from a settled bank
  for (genvar g = 0; g < `NUM_BANKS; g++)
  begin : g_cnt_chk
    cnt_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (load_rcd[g] || load_rp[g]) |-> (cnt_q[g] == '0));
  end

  rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && wr_en));

  // A NOP can never be flagged
  no_illegal_nop: assert property (@(posedge clk) disable iff (!rst_n)
    illegal_cmd |-> ($past(cmd) != NOP));

endmodule

//--- src/cmd_delay.sv
`timescale 1ns/1ps

module cmd_delay
#(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic [DEPTH-1:0] valid_q;        // One bit per stage
  payload_t         data_q [DEPTH]; // Stage 0 nearest the input

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      valid_q <= '0; // Line empty
    else
    begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++)
        valid_q[i] <= valid_q[i-1];
    end
  end

  always_ff @(posedge clk)
  begin
    data_q[0] <= in_data;
    for (int i = 1; i < DEPTH; i++)
      data_q[i] <= data_q[i-1];
  end

  assign out_valid = valid_q[DEPTH-1];
  assign out_data  = data_q[DEPTH-1];

  depth_min: assert property (@(posedge clk) DEPTH >= 1);

endmodule

//--- src/bank_array.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module bank_array
  import dram_pkg::*;
(
  input  logic     clk,
  input  logic     rd_en,
  input  wr_req_t  rd_req,  // Current RD address
  input  logic     wr_en,
  input  wr_req_t  wr_req,  // Delayed WR address
  input  dq_word_t wr_data,
  output dq_word_t rd_data,
  output logic     rd_valid
);

  localparam int ROWS = 2 ** `ROW_WIDTH;
  localparam int COLS = 2 ** `COL_WIDTH;

  // NUM_BANKS x ROWS x COLS words
  dq_word_t mem [`NUM_BANKS][ROWS][COLS];

  // Write port, CWL edges after the WR
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_req.bank][wr_req.row][wr_req.col] <= wr_data;
  end

  // Read port on the RD edge
  // Same-edge write is not visible here
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_data <= mem[rd_req.bank][rd_req.row][rd_req.col];
  end

  // Valid tag travelling with rd_data
  always_ff @(posedge clk)
  begin
    rd_valid <= rd_en;
  end

endmodule

//--- src/dram_device.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_device
  import dram_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   act_n,
  input  logic [`ADDR_WIDTH-1:0] a,
  input  logic [`BG_WIDTH-1:0]   bg,
  input  logic [`BA_WIDTH-1:0]   ba,
  input  logic                   cs_n,
  input  logic                   cke,
  input  logic                   parity,
  input  dq_word_t               dq_in,
  output dq_word_t               dq_out,
  output logic                   dq_valid,
  output logic                   illegal_cmd,
  output logic                   alert
);

  dram_cmd_e cmd;
  bank_id_t  bank;
  logic      par_err;
  logic      rd_en;
  logic      wr_en;
  wr_req_t   req;        // Address of the current access
  logic      wr_pending; // Delayed WR reaches its data cycle
  wr_req_t   wr_req_d;
  dq_word_t  rd_word;    // Array output, one edge after RD
  logic      rd_word_valid;

  cmd_decoder u_decoder (
    .act_n   (act_n),
    .a       (a),
    .bg      (bg),
    .ba      (ba),
    .cs_n    (cs_n),
    .cke     (cke),
    .parity  (parity),
    .cmd     (cmd),
    .bank    (bank),
    .par_err (par_err)
  );

  bank_ctrl u_bank_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .bank        (bank),
    .a           (a),
    .par_err     (par_err),
    .rd_en       (rd_en),
    .wr_en       (wr_en),
    .req         (req),
    .illegal_cmd (illegal_cmd),
    .alert       (alert)
  );

  // WR address waits CWL edges for its data
  cmd_delay #(.payload_t(wr_req_t), .DEPTH(`CWL)) u_wr_delay (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (wr_en),
    .in_data   (req),
    .out_valid (wr_pending),
    .out_data  (wr_req_d)
  );

  bank_array u_array (
    .clk      (clk),
    .rd_en    (rd_en),
    .rd_req   (req),
    .wr_en    (wr_pending),
    .wr_req   (wr_req_d),
    .wr_data  (dq_in),
    .rd_data  (rd_word),
    .rd_valid (rd_word_valid)
  );

  // Array register counts as the first CL cycle
  cmd_delay #(.payload_t(dq_word_t), .DEPTH(`CL - 1)) u_rd_delay (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (rd_word_valid),
    .in_data   (rd_word),
    .out_valid (dq_valid),
    .out_data  (dq_out)
  );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 5
)
(
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk; // Free running
  end

  // Released on the last reset edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

//--- tests/dram_tb.sv
`timescale 1ns/1ps
`include "dram_macros.svh"

module dram_tb
  import dram_pkg::*;
();

  localparam int PERIOD_NS = 4;
  localparam int N_RESET   = 16;  // Quiet NOPs after reset
  localparam int N_LEGAL   = 400;
  localparam int N_ANY     = 300;
  localparam int N_PARITY  = 200;
  localparam int N_DIRECT  = 8 + `NUM_BANKS * 24; // Bound for one directed test
  localparam int N_DRAIN   = `CL + 2;
  localparam int TOTAL_STEPS = N_RESET + N_LEGAL + N_ANY + N_PARITY + 2 * N_DIRECT +
                               6 * N_DRAIN;
  localparam int ROWS = 2 ** `ROW_WIDTH;
  localparam int COLS = 2 ** `COL_WIDTH;

  logic                   clk;
  logic                   rst_n;
  logic                   act_n;
  logic [`ADDR_WIDTH-1:0] a;
  logic [`BG_WIDTH-1:0]   bg;
  logic [`BA_WIDTH-1:0]   ba;
  logic                   cs_n;
  logic                   cke;
  logic                   parity;
  dq_word_t               dq_in;
  dq_word_t               dq_out;
  logic                   dq_valid;
  logic                   illegal_cmd;
  logic                   alert;

  logic [31:0] seed = 32'h22920e1b;

  // Reference model of the banks and the array
  bank_state_e     m_state [`NUM_BANKS];
  int              m_ready [`NUM_BANKS]; // Edge that ends OPENING or CLOSING
  logic [3:0]      m_row   [`NUM_BANKS];
  dq_word_t        m_mem   [`NUM_BANKS][ROWS][COLS];
  bit              m_known [`NUM_BANKS][ROWS][COLS]; // Cell written at least once

  // Expected outputs in a ring indexed by cycle
  bit       ev [16]; // dq_valid
  dq_word_t ed [16];
  bit       ek [16]; // dq_out comparable
  bit       ei [16]; // illegal_cmd
  bit       ea [16]; // alert
  bit       wv [16]; // Write data due at this edge
  dq_word_t wd [16];
  wr_req_t  wa [16];

  int cyc = 16; // Edge that samples the next command
  int errors;
  int test_errs;
  int tests_run;
  int tests_failed;

  tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(5)) u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dram_device DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .act_n       (act_n),
    .a           (a),
    .bg          (bg),
    .ba          (ba),
    .cs_n        (cs_n),
    .cke         (cke),
    .parity      (parity),
    .dq_in       (dq_in),
    .dq_out      (dq_out),
    .dq_valid    (dq_valid),
    .illegal_cmd (illegal_cmd),
    .alert       (alert)
  );

  // LCG whose upper bits are the better ones
  function automatic int unsigned rand_below(input int unsigned n);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return (seed >> 16) % n;
  endfunction

  function automatic int slot(input int n);
    return n % 16;
  endfunction

  // Finish any spacing that has run out by edge cyc
  function automatic void settle_banks();
    for (int i = 0; i < `NUM_BANKS; i++)
    begin
      if (m_state[i] == OPENING && cyc >= m_ready[i])
        m_state[i] = OPEN;
      else if (m_state[i] == CLOSING && cyc >= m_ready[i])
        m_state[i] = IDLE;
    end
  endfunction

  function automatic void model_cmd(input dram_cmd_e c, input bank_id_t b,
                                    input logic [3:0] rc);
    int k;
    case (c)
      ACT:
        if (m_state[b] == IDLE)
        begin
          m_state[b] = OPENING;
          m_ready[b] = cyc + `T_RCD;
          m_row[b]   = rc;
        end
        else
          ei[slot(cyc + 1)] = 1'b1;
      RD:
        if (m_state[b] == OPEN)
        begin
          k = slot(cyc + `CL); // Data shows CL edges later
          ev[k] = 1'b1;
          ek[k] = m_known[b][m_row[b]][rc];
          ed[k] = m_mem[b][m_row[b]][rc];
        end
        else
          ei[slot(cyc + 1)] = 1'b1;
      WR:
        if (m_state[b] == OPEN)
        begin
          k = slot(cyc + `CWL);
          wv[k] = 1'b1;
          wd[k] = dq_word_t'(rand_below(1 << 16));
          wa[k] = '{bank: b, row: m_row[b], col: rc};
        end
        else
          ei[slot(cyc + 1)] = 1'b1;
      PRE:
        if (m_state[b] == OPEN)
        begin
          m_state[b] = CLOSING;
          m_ready[b] = cyc + `T_RP;
        end
        else
          ei[slot(cyc + 1)] = 1'b1;
      PREA:
        for (int i = 0; i < `NUM_BANKS; i++)
          if (m_state[i] == OPEN)
          begin
            m_state[i] = CLOSING;
            m_ready[i] = cyc + `T_RP;
          end
      default: ;
    endcase
  endfunction

  // Outputs left by the previous rising edge
  task automatic check_outputs();
    int k;
    k = slot(cyc);
    assert (dq_valid === ev[k])
    else
    begin
      $display("Error at time %0t: dq_valid is %b, expected %b", $time, dq_valid, ev[k]);
      errors++;
    end
    if (ev[k] && ek[k])
    begin
      assert (dq_out === ed[k])
      else
      begin
        $display("Error at time %0t: dq_out is %h, expected %h", $time, dq_out, ed[k]);
        errors++;
      end
    end
    assert (illegal_cmd === ei[k])
    else
    begin
      $display("Error at time %0t: illegal_cmd is %b, expected %b", $time, illegal_cmd, ei[k]);
      errors++;
    end
    assert (alert === ea[k])
    else
    begin
      $display("Error at time %0t: alert is %b, expected %b", $time, alert, ea[k]);
      errors++;
    end
    ev[k] = 1'b0;
    ek[k] = 1'b0;
    ei[k] = 1'b0;
    ea[k] = 1'b0;
  endtask

  // One command cycle driven on the falling edge
  task automatic step(input dram_cmd_e c, input bank_id_t b, input logic [3:0] rc,
                      input bit bad_par);
    logic [`ADDR_WIDTH-1:0] a_v;
    logic                   act_v;
    int                     k;
    @(negedge clk);
    check_outputs();
    settle_banks();
    if (bad_par)
      ea[slot(cyc + 1)] = 1'b1; // Dropped command raises alert only
    else
      model_cmd(c, b, rc);
    act_v = (c != ACT);
    a_v   = {3'b111, 14'(rand_below(1 << 14))}; // Junk in unused pins
    case (c)
      RD:   a_v[16:14] = 3'b101;
      WR:   a_v[16:14] = 3'b100;
      PRE:  a_v[16:14] = 3'b010;
      PREA: a_v[16:14] = 3'b010;
      default: ;
    endcase
    if (c == PRE || c == PREA)
      a_v[10] = (c == PREA); // A10 selects all banks
    a_v[3:0] = rc;
    act_n  = act_v;
    a      = a_v;
    bg     = b[1];
    ba     = b[0];
    cs_n   = 1'b0;
    cke    = 1'b1;
    parity = (^{act_v, a_v, b}) ^ bad_par;
    k = slot(cyc);
    if (wv[k])
    begin
      dq_in = wd[k]; // Only in the data cycle
      m_mem[wa[k].bank][wa[k].row][wa[k].col]   = wd[k];
      m_known[wa[k].bank][wa[k].row][wa[k].col] = 1'b1;
      wv[k] = 1'b0;
    end
    else
      dq_in = '0;
    cyc++;
  endtask

  task automatic nops(input int n);
    repeat (n) step(NOP, 2'd0, 4'd0, 1'b0);
  endtask

  // Let pending opens finish and close everything
  task automatic quiesce();
    nops(`T_RCD);
    step(PREA, 2'd0, 4'd0, 1'b0);
    nops(`T_RP);
  endtask

  // Only commands the model allows
  task automatic legal_step();
    bank_id_t    b;
    logic [3:0]  row;
    logic [3:0]  col;
    int unsigned r;
    dram_cmd_e   c;
    b   = bank_id_t'(rand_below(4));
    row = 4'(rand_below(2));
    col = 4'(rand_below(4)); // Few cells for frequent read hits
    r   = rand_below(100);
    settle_banks();
    c = NOP;
    if (m_state[b] == IDLE && r < 70)
      c = ACT;
    else if (m_state[b] == OPEN)
      c = (r < 40) ? RD : (r < 80) ? WR : (r < 95) ? PRE : PREA;
    step(c, b, (c == ACT) ? row : col, 1'b0);
  endtask

  task automatic any_step(input int unsigned bad_pct);
    dram_cmd_e  c;
    bank_id_t   b;
    logic [3:0] rc;
    bit         bad;
    c   = dram_cmd_e'(rand_below(6));
    b   = bank_id_t'(rand_below(4));
    rc  = 4'(rand_below(4));
    bad = rand_below(100) < bad_pct;
    step(c, b, rc, bad);
  endtask

  task automatic write_landing();
    bank_id_t   b;
    logic [3:0] row;
    logic [3:0] col;
    quiesce();
    for (int i = 0; i < `NUM_BANKS; i++)
    begin
      b   = bank_id_t'(i);
      row = 4'(rand_below(ROWS));
      col = 4'(rand_below(COLS));
      step(ACT, b, row, 1'b0);
      nops(`T_RCD - 1);
      step(WR, b, col, 1'b0);
      nops(`CWL - 1);
      step(RD, b, col, 1'b0); // Same edge as the data returns the old word
      step(RD, b, col, 1'b0); // New word
      step(PRE, b, 4'd0, 1'b0);
      nops(`CL);
    end
  endtask

  task automatic timing_rules();
    bank_id_t   b;
    bank_id_t   b2;
    logic [3:0] row;
    quiesce();
    for (int i = 0; i < `NUM_BANKS; i++)
    begin
      b   = bank_id_t'(i);
      b2  = b + 1'b1;
      row = 4'(rand_below(ROWS));
      step(ACT, b, row, 1'b0);
      step(RD, b, 4'd1, 1'b0);   // Inside tRCD
      step(WR, b, 4'd2, 1'b0);
      nops(`T_RCD - 3);
      step(PRE, b, 4'd0, 1'b0);
      step(ACT, b, row, 1'b0);   // Inside tRP
      nops(`T_RP - 2);
      step(ACT, b, row, 1'b0);
      step(ACT, b2, row, 1'b0);
      nops(`T_RCD);
      step(PREA, b, 4'd0, 1'b0); // Both open banks close
      step(RD, b, 4'd1, 1'b0);
      step(ACT, b2, row, 1'b0);
      nops(`T_RP);
    end
  endtask

  task automatic finish_test(input string name);
    nops(N_DRAIN); // Collect late reads
    tests_run++;
    if (errors == test_errs)
      $display("Test %-14s passed", name);
    else
    begin
      tests_failed++;
      $display("Test %-14s failed with %0d errors", name, errors - test_errs);
    end
    test_errs = errors;
  endtask

  initial
  begin
    act_n  = 1'b1;
    a      = '0;
    bg     = '0;
    ba     = '0;
    cs_n   = 1'b1;
    cke    = 1'b1;
    parity = 1'b0;
    dq_in  = '0;
    for (int i = 0; i < `NUM_BANKS; i++)
    begin
      m_state[i] = IDLE;
      m_ready[i] = 0;
    end
    wait (rst_n === 1'b1);
    nops(N_RESET);
    finish_test("reset_quiet");
    repeat (N_LEGAL) legal_step();
    finish_test("legal_traffic");
    write_landing();
    finish_test("write_landing");
    repeat (N_ANY) any_step(0);
    finish_test("state_errors");
    timing_rules();
    finish_test("timing_rules");
    repeat (N_PARITY) any_step(30);
    finish_test("parity_errors");
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // Reset, all steps and a margin
  initial
  begin
    #((TOTAL_STEPS + 5 + 200) * PERIOD_NS);
    $display("Timeout: the tests did not finish within %0d cycles", TOTAL_STEPS + 205);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+src
src/dram_pkg.sv
src/cmd_decoder.sv
src/bank_ctrl.sv
src/cmd_delay.sv
src/bank_array.sv
src/dram_device.sv
tests/tb_clock.sv
tests/dram_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DRAM device testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f vlog.f --top-module dram_tb -o dram_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/dram_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
else
  echo "Pass message not found in the simulation output"
  exit 1
fi
